//--- filelist.f
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/reg_bank.sv
hdl/alu.sv
hdl/sequencer.sv
hdl/cpu_top.sv
verif/cpu_assert.sv
verif/tb_cpu.sv

//--- verif/tb_cpu.sv
`default_nettype none

module tb_cpu
    import isa_pkg::*;
;

    timeunit 1ns;
    timeprecision 1ps;

    // about 60 instructions at 12 cycles worst case, with wide margin
    localparam int MAX_CYCLES = 8000;

    logic        clock;
    logic        rst_n;
    logic        mem_req_valid;
    logic        mem_req_write;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_req_ready;
    logic        mem_rsp_valid;
    logic [31:0] mem_rdata;
    logic        halted;

    logic [31:0] mem [256];
    integer      seed = 32'h553c_6a35;
    int          rsp_count;
    logic [7:0]  rsp_addr;
    int          prog_len = 0;
    int          cycle_count = 0;
    int          error_count = 0;
    int          timeout_count = 0;

    cpu_top #(
        .NUM_REGS (8),
        .RESET_PC ('0)
    ) u_dut (
        .clock         (clock),
        .rst_n         (rst_n),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rdata     (mem_rdata),
        .halted        (halted)
    );

    always #10 clock = ~clock;

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
    end

    // memory with random back-pressure and a read latency of 1 to 3 cycles
    always @(posedge clock)
    begin : memory_model
        logic [31:0] ready_draw;
        logic [31:0] lat_draw;
        int          latency;
        if (!rst_n)
        begin
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
            mem_rdata     <= '0;
            rsp_count     <= 0;
        end
        else
        begin
            ready_draw    = $random(seed);
            mem_req_ready <= ready_draw[0] | ready_draw[1];
            mem_rsp_valid <= 1'b0;
            if (rsp_count == 1)
            begin
                mem_rsp_valid <= 1'b1;
                mem_rdata     <= mem[rsp_addr];
            end
            if (rsp_count != 0)
            begin
                rsp_count <= rsp_count - 1;
            end
            if (mem_req_valid && mem_req_ready)
            begin
                if (mem_req_write)
                begin
                    mem[mem_addr[7:0]] <= mem_wdata;
                end
                else
                begin
                    lat_draw = $random(seed);
                    latency  = 1 + lat_draw[7:0] % 3;
                    rsp_addr <= mem_addr[7:0];
                    if (latency == 1)
                    begin
                        mem_rsp_valid <= 1'b1;
                        mem_rdata     <= mem[mem_addr[7:0]];
                    end
                    else
                    begin
                        rsp_count <= latency - 1;
                    end
                end
            end
        end
    end

    function automatic logic [31:0] encode_instr(opcode_t op, int rd, int ra, int rb,
                                                 logic hl, logic [15:0] imm);
        return {imm, hl, 3'(rd), 3'(rb), 3'(ra), op};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[prog_len] = word;
        prog_len++;
    endtask

    task automatic emit_alu(input opcode_t op, input int rd, input int ra, input int rb);
        emit(encode_instr(op, rd, ra, rb, 1'b0, 16'h0000));
    endtask

    // r1 holds the data base 0x80
    task automatic emit_store(input int rb, input logic [15:0] offset);
        emit(encode_instr(OP_STORE, 0, 1, rb, 1'b0, offset));
    endtask

    // stores 0x0a when the branch on the flag is taken, 0x0b when not
    task automatic emit_flag_test(input int flag, input logic [15:0] offset);
        emit(encode_instr(OP_LDI, 7, 0, 0, 1'b0, 16'h000a));
        emit(encode_instr(OP_BRF, 0, flag, 0, 1'b0, 16'(prog_len + 2)));
        emit(encode_instr(OP_LDI, 7, 0, 0, 1'b0, 16'h000b));
        emit_store(7, offset);
    endtask

    task automatic build_memory();
        for (int i = 0; i < 256; i++)
        begin
            mem[i] = 32'hbad0_0000 | i;
        end
        mem[8'h80] = 32'hffff_fff0;
        mem[8'h81] = 32'h0000_0025;
        mem[8'h82] = 32'h1234_5678;

        emit(encode_instr(OP_LDI, 1, 0, 0, 1'b0, 16'h0080));
        emit(encode_instr(OP_LOAD, 2, 1, 0, 1'b0, 16'h0000));
        emit(encode_instr(OP_LOAD, 3, 1, 0, 1'b0, 16'h0001));
        emit_alu(OP_ADD, 4, 2, 3);
        emit_store(4, 16'h0040);
        emit_alu(OP_SUB, 5, 3, 2);
        emit_store(5, 16'h0041);
        emit_alu(OP_AND, 6, 2, 3);
        emit_store(6, 16'h0042);
        emit_alu(OP_OR, 6, 2, 3);
        emit_store(6, 16'h0043);
        emit_alu(OP_XOR, 6, 2, 3);
        emit_store(6, 16'h0044);
        emit_alu(OP_SHL, 6, 3, 3);
        emit_store(6, 16'h0045);
        emit_alu(OP_SHR, 6, 2, 3);
        emit_store(6, 16'h0046);
        emit_alu(OP_CMPEQ, 0, 2, 3);
        emit_store(0, 16'h0047);
        emit_alu(OP_CMPLT, 6, 3, 2);
        emit_store(6, 16'h0048);
        emit(encode_instr(OP_LDI, 6, 0, 0, 1'b0, 16'hbeef));
        emit(encode_instr(OP_LDI, 6, 6, 0, 1'b1, 16'hdead));
        emit_store(6, 16'h0049);

        // carry, borrow, compare-cleared and never-written flags
        emit_flag_test(4, 16'h004a);
        emit_flag_test(5, 16'h004b);
        emit_flag_test(0, 16'h004c);
        emit_flag_test(2, 16'h004d);
        emit_alu(OP_ADD, 6, 3, 3);
        emit_flag_test(6, 16'h004e);
        emit_alu(OP_AND, 6, 0, 2);
        emit_flag_test(6, 16'h004f);

        emit(encode_instr(OP_LOAD, 4, 1, 0, 1'b0, 16'h0002));
        emit_alu(OP_ADD, 4, 4, 3);
        emit_store(4, 16'h0002);
        emit_alu(OP_HALT, 0, 0, 0);
    endtask

    task automatic check_word(input logic [7:0] addr, input logic [31:0] expected,
                              input string name);
        if (mem[addr] !== expected)
        begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, mem[addr]);
            error_count++;
        end
    endtask

    task automatic check_results();
        check_word(8'hc0, 32'h0000_0015, "add_result");
        check_word(8'hc1, 32'h0000_0035, "sub_result");
        check_word(8'hc2, 32'h0000_0020, "and_result");
        check_word(8'hc3, 32'hffff_fff5, "or_result");
        check_word(8'hc4, 32'hffff_ffd5, "xor_result");
        check_word(8'hc5, 32'h0000_04a0, "shl_result");
        check_word(8'hc6, 32'h07ff_ffff, "shr_result");
        check_word(8'hc7, 32'h0000_0000, "cmpeq_result");
        check_word(8'hc8, 32'h0000_0001, "cmplt_result");
        check_word(8'hc9, 32'hdead_beef, "ldi_word");
        check_word(8'hca, 32'h0000_000a, "carry_branch");
        check_word(8'hcb, 32'h0000_000a, "borrow_branch");
        check_word(8'hcc, 32'h0000_000b, "cleared_flag_branch");
        check_word(8'hcd, 32'h0000_000a, "reset_flag_branch");
        check_word(8'hce, 32'h0000_000b, "no_carry_branch");
        check_word(8'hcf, 32'h0000_000a, "zero_flag_branch");
        check_word(8'h82, 32'h1234_569d, "load_add_store");
    endtask

    initial
    begin
        clock         = 1'b0;
        rst_n         = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rdata     = '0;
        build_memory();

        repeat (3) @(posedge clock);
        rst_n <= 1'b1;

        while (!halted && cycle_count < MAX_CYCLES)
        begin
            @(posedge clock);
        end

        if (!halted)
        begin
            $display("timeout: core did not halt within %0d cycles", MAX_CYCLES);
            timeout_count = 1;
        end
        else
        begin
            // keep running so the halt checks see a few idle cycles
            repeat (8) @(posedge clock);
            check_results();
        end

        $display("%0d data errors, %0d assertion failures, %0d timeouts",
                 error_count, u_dut.u_chk.fail_count, timeout_count);
        if (error_count == 0 && u_dut.u_chk.fail_count == 0 && timeout_count == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/cpu_assert.sv
`default_nettype none

module cpu_assert
    import isa_pkg::*;
(
    input wire logic            clock,
    input wire logic            rst_n,
    input wire logic            mem_req_valid,
    input wire logic            mem_req_write,
    input wire logic [XLEN-1:0] mem_addr,
    input wire logic [XLEN-1:0] mem_wdata,
    input wire logic            mem_req_ready,
    input wire logic            mem_rsp_valid,
    input wire logic            halted
);

    timeunit 1ns;
    timeprecision 1ps;

    int   fail_count = 0;
    logic read_open;

    // one read in flight between its transfer and its response
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            read_open <= 1'b0;
        end
        else if (mem_rsp_valid)
        begin
            read_open <= 1'b0;
        end
        else if (mem_req_valid && mem_req_ready && !mem_req_write)
        begin
            read_open <= 1'b1;
        end
    end

    req_stable: assert property (@(posedge clock) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=>
            mem_req_valid && $stable(mem_addr) && $stable(mem_req_write) &&
            (!mem_req_write || $stable(mem_wdata)))
    else
    begin
        $error("memory request changed while stalled");
        fail_count++;
    end

    halt_sticky: assert property (@(posedge clock) disable iff (!rst_n)
        halted |=> halted && !mem_req_valid)
    else
    begin
        $error("core left halt or issued a request after halt");
        fail_count++;
    end

    rsp_after_read: assert property (@(posedge clock) disable iff (!rst_n)
        mem_rsp_valid |-> read_open)
    else
    begin
        $error("read response without an outstanding read");
        fail_count++;
    end

    single_read: assert property (@(posedge clock) disable iff (!rst_n)
        mem_req_valid |-> !read_open)
    else
    begin
        $error("new request while a read is outstanding");
        fail_count++;
    end

    // outputs are quiet from the first reset edge on
    reset_quiet: assert property (@(posedge clock)
        !rst_n |=> !mem_req_valid && !halted)
    else
    begin
        $error("request or halt active during reset");
        fail_count++;
    end

endmodule

bind cpu_top cpu_assert u_chk (
    .clock         (clock),
    .rst_n         (rst_n),
    .mem_req_valid (mem_req_valid),
    .mem_req_write (mem_req_write),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .halted        (halted)
);

`default_nettype wire

//--- hdl/cpu_top.sv
`default_nettype none

module cpu_top
    import isa_pkg::*;
#(
    parameter int              NUM_REGS = 8,
    parameter logic [XLEN-1:0] RESET_PC = '0
)
(
    input  wire logic            clock,
    input  wire logic            rst_n,

    output logic                 mem_req_valid,
    output logic                 mem_req_write,
    output logic [XLEN-1:0]      mem_addr,
    output logic [XLEN-1:0]      mem_wdata,
    input  wire logic            mem_req_ready,
    input  wire logic            mem_rsp_valid,
    input  wire logic [XLEN-1:0] mem_rdata,

    output logic                 halted
);

    logic [XLEN-1:0]  instr;
    opcode_t          opcode;
    logic             high_low;
    logic [IMM_W-1:0] imm;
    reg_idx_t         ra;
    reg_idx_t         rb;
    reg_idx_t         rd;

    logic [XLEN-1:0]  src_a;
    logic [XLEN-1:0]  src_b;
    logic             flag_a;
    logic [XLEN-1:0]  alu_result;
    logic             alu_flag;
    logic             branch_taken;

    logic             reg_wr_en;
    logic [XLEN-1:0]  reg_wr_data;
    logic             flag_wr_en;
    logic             flag_wr_data;

    // instruction fields
    assign opcode   = opcode_t'(instr[OPC_LSB +: OPC_W]);
    assign ra       = instr[RA_LSB +: REG_W];
    assign rb       = instr[RB_LSB +: REG_W];
    assign rd       = instr[RD_LSB +: REG_W];
    assign high_low = instr[HL_BIT];
    assign imm      = instr[IMM_LSB +: IMM_W];

    sequencer #(
        .RESET_PC (RESET_PC)
    ) u_seq (
        .clock         (clock),
        .rst_n         (rst_n),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rdata     (mem_rdata),
        .instr         (instr),
        .alu_result    (alu_result),
        .alu_flag      (alu_flag),
        .branch_taken  (branch_taken),
        .src_b         (src_b),
        .reg_wr_en     (reg_wr_en),
        .reg_wr_data   (reg_wr_data),
        .flag_wr_en    (flag_wr_en),
        .flag_wr_data  (flag_wr_data),
        .halted        (halted)
    );

    alu u_alu (
        .opcode       (opcode),
        .high_low     (high_low),
        .imm          (imm),
        .src_a        (src_a),
        .src_b        (src_b),
        .flag_a       (flag_a),
        .result       (alu_result),
        .flag_out     (alu_flag),
        .branch_taken (branch_taken)
    );

    reg_bank #(
        .entry_t     (logic [XLEN-1:0]),
        .NUM_REGS    (NUM_REGS),
        .RESET_VALUE ('0)
    ) u_regs (
        .clock     (clock),
        .rst_n     (rst_n),
        .rd_idx_a  (ra),
        .rd_idx_b  (rb),
        .rd_data_a (src_a),
        .rd_data_b (src_b),
        .wr_en     (reg_wr_en),
        .wr_idx    (rd),
        .wr_data   (reg_wr_data)
    );

    // only the source-A flag feeds the ALU
    reg_bank #(
        .entry_t     (logic),
        .NUM_REGS    (NUM_REGS),
        .RESET_VALUE (1'b1)
    ) u_flags (
        .clock     (clock),
        .rst_n     (rst_n),
        .rd_idx_a  (ra),
        .rd_idx_b  (rb),
        .rd_data_a (flag_a),
        .rd_data_b (),
        .wr_en     (flag_wr_en),
        .wr_idx    (rd),
        .wr_data   (flag_wr_data)
    );

endmodule

`default_nettype wire

//--- hdl/sequencer.sv
`default_nettype none

module sequencer
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
)
(
    input  wire logic            clock,
    input  wire logic            rst_n,

    output logic                 mem_req_valid,
    output logic                 mem_req_write,
    output logic [XLEN-1:0]      mem_addr,
    output logic [XLEN-1:0]      mem_wdata,
    input  wire logic            mem_req_ready,
    input  wire logic            mem_rsp_valid,
    input  wire logic [XLEN-1:0] mem_rdata,

    output logic [XLEN-1:0]      instr,

    input  wire logic [XLEN-1:0] alu_result,
    input  wire logic            alu_flag,
    input  wire logic            branch_taken,
    input  wire logic [XLEN-1:0] src_b,

    output logic                 reg_wr_en,
    output logic [XLEN-1:0]      reg_wr_data,
    output logic                 flag_wr_en,
    output logic                 flag_wr_data,

    output logic                 halted
);

    seq_state_t      state;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] ir;
    opcode_t         opcode;
    alu_kind_t       kind;

    assign opcode  = opcode_t'(ir[OPC_LSB +: OPC_W]);
    assign kind    = op_kind(opcode);
    assign pc_next = branch_taken ? {{(XLEN-IMM_W){1'b0}}, ir[IMM_LSB +: IMM_W]} : pc + 1'b1;

    // request is registered so it holds still under back-pressure
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            state         <= ST_FETCH;
            pc            <= RESET_PC;
            mem_req_valid <= 1'b0;
        end
        else
        begin
            case (state)
                ST_FETCH:
                begin
                    if (!mem_req_valid)
                    begin
                        // first fetch after reset
                        mem_req_valid <= 1'b1;
                        mem_req_write <= 1'b0;
                        mem_addr      <= pc;
                    end
                    else if (mem_req_ready)
                    begin
                        mem_req_valid <= 1'b0;
                        state         <= ST_WAIT_INSTR;
                    end
                end
                ST_WAIT_INSTR:
                begin
                    if (mem_rsp_valid)
                    begin
                        ir    <= mem_rdata;
                        state <= ST_EXECUTE;
                    end
                end
                ST_EXECUTE:
                begin
                    if (kind == KIND_HALT)
                    begin
                        state <= ST_HALT;
                    end
                    else if (kind == KIND_MEM)
                    begin
                        pc            <= pc + 1'b1;
                        mem_req_valid <= 1'b1;
                        mem_req_write <= (opcode == OP_STORE);
                        mem_addr      <= alu_result;
                        mem_wdata     <= src_b;
                        state         <= ST_MEM;
                    end
                    else
                    begin
                        pc            <= pc_next;
                        mem_req_valid <= 1'b1;
                        mem_req_write <= 1'b0;
                        mem_addr      <= pc_next;
                        state         <= ST_FETCH;
                    end
                end
                ST_MEM:
                begin
                    if (mem_req_ready && mem_req_write)
                    begin
                        // store done, next fetch goes straight out
                        mem_req_write <= 1'b0;
                        mem_addr      <= pc;
                        state         <= ST_FETCH;
                    end
                    else if (mem_req_ready)
                    begin
                        mem_req_valid <= 1'b0;
                        state         <= ST_WAIT_DATA;
                    end
                end
                ST_WAIT_DATA:
                begin
                    if (mem_rsp_valid)
                    begin
                        mem_req_valid <= 1'b1;
                        mem_req_write <= 1'b0;
                        mem_addr      <= pc;
                        state         <= ST_FETCH;
                    end
                end
                default:
                begin
                    state <= ST_HALT;
                end
            endcase
        end
    end

    // load data bypasses the ALU
    assign reg_wr_en    = ((state == ST_EXECUTE) && (kind == KIND_WRITE)) ||
                          ((state == ST_WAIT_DATA) && mem_rsp_valid);
    assign reg_wr_data  = (state == ST_WAIT_DATA) ? mem_rdata : alu_result;
    assign flag_wr_en   = (state == ST_EXECUTE) && (kind == KIND_WRITE);
    assign flag_wr_data = alu_flag;

    assign instr  = ir;
    assign halted = (state == ST_HALT);

endmodule

`default_nettype wire

//--- hdl/alu.sv
`default_nettype none

module alu
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire opcode_t          opcode,
    input  wire logic             high_low,
    input  wire logic [IMM_W-1:0] imm,
    input  wire logic [XLEN-1:0]  src_a,
    input  wire logic [XLEN-1:0]  src_b,
    input  wire logic             flag_a,

    output logic [XLEN-1:0]       result,
    output logic                  flag_out,
    output logic                  branch_taken
);

    logic [XLEN-1:0] imm_ext;
    logic [XLEN:0]   wide;

    assign imm_ext = {{(XLEN-IMM_W){1'b0}}, imm};

    always_comb
    begin
        wide     = '0;
        result   = '0;
        flag_out = 1'b0;
        case (opcode)
            OP_LDI:
            begin
                // select 1 keeps the lower half of source A
                result   = high_low ? {imm, src_a[IMM_W-1:0]} : imm_ext;
                flag_out = zero_flag(result);
            end
            OP_ADD:
            begin
                wide     = {1'b0, src_a} + {1'b0, src_b};
                result   = wide[XLEN-1:0];
                flag_out = wide[XLEN];
            end
            OP_SUB:
            begin
                // top bit of the widened difference is the borrow
                wide     = {1'b0, src_a} - {1'b0, src_b};
                result   = wide[XLEN-1:0];
                flag_out = wide[XLEN];
            end
            OP_AND:
            begin
                result   = src_a & src_b;
                flag_out = zero_flag(result);
            end
            OP_OR:
            begin
                result   = src_a | src_b;
                flag_out = zero_flag(result);
            end
            OP_XOR:
            begin
                result   = src_a ^ src_b;
                flag_out = zero_flag(result);
            end
            OP_SHL:
            begin
                result   = src_a << src_b[4:0];
                flag_out = zero_flag(result);
            end
            OP_SHR:
            begin
                result   = src_a >> src_b[4:0];
                flag_out = zero_flag(result);
            end
            OP_CMPEQ:
            begin
                result   = {{(XLEN-1){1'b0}}, src_a == src_b};
                flag_out = result[0];
            end
            OP_CMPLT:
            begin
                result   = {{(XLEN-1){1'b0}}, src_a < src_b};
                flag_out = result[0];
            end
            OP_LOAD, OP_STORE:
            begin
                // word address of the data access
                result = src_a + imm_ext;
            end
            default:
            begin
                result = '0;
            end
        endcase
    end

    assign branch_taken = (op_kind(opcode) == KIND_BRANCH) &&
                          ((opcode == OP_JMP) || flag_a);

endmodule

`default_nettype wire

//--- hdl/reg_bank.sv
`default_nettype none

module reg_bank
    import isa_pkg::*;
#(
    parameter type    entry_t     = logic [31:0],
    parameter int     NUM_REGS    = 8,
    parameter entry_t RESET_VALUE = entry_t'(0)
)
(
    input  wire logic     clock,
    input  wire logic     rst_n,

    input  wire reg_idx_t rd_idx_a,
    input  wire reg_idx_t rd_idx_b,
    output entry_t        rd_data_a,
    output entry_t        rd_data_b,

    input  wire logic     wr_en,
    input  wire reg_idx_t wr_idx,
    input  wire entry_t   wr_data
);

    entry_t bank [NUM_REGS];

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                bank[i] <= RESET_VALUE;
            end
        end
        else if (wr_en)
        begin
            bank[wr_idx] <= wr_data;
        end
    end

    // reads see the stored value, a write lands on the next edge
    assign rd_data_a = bank[rd_idx_a];
    assign rd_data_b = bank[rd_idx_b];

endmodule

`default_nettype wire

//--- hdl/core_pkg.sv
`default_nettype none

package core_pkg;

    import isa_pkg::*;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_WAIT_INSTR,
        ST_EXECUTE,
        ST_MEM,
        ST_WAIT_DATA,
        ST_HALT
    } seq_state_t;

    typedef enum logic [2:0] {
        KIND_WRITE,
        KIND_MEM,
        KIND_BRANCH,
        KIND_HALT,
        KIND_NONE
    } alu_kind_t;

    // what an opcode does to the core state
    function automatic alu_kind_t op_kind(opcode_t op);
        case (op)
            OP_LDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
            OP_SHL, OP_SHR, OP_CMPEQ, OP_CMPLT: return KIND_WRITE;
            OP_LOAD, OP_STORE:                   return KIND_MEM;
            OP_BRF, OP_JMP:                      return KIND_BRANCH;
            OP_HALT:                             return KIND_HALT;
            default:                             return KIND_NONE;
        endcase
    endfunction

    // flag rule for logic, shift and immediate ops
    function automatic logic zero_flag(logic [XLEN-1:0] value);
        return (value == '0);
    endfunction

endpackage

`default_nettype wire

//--- hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // data and address width
    localparam int XLEN = 32;

    // instruction field layout
    localparam int OPC_LSB = 0;
    localparam int OPC_W   = 6;
    localparam int RA_LSB  = 6;
    localparam int RB_LSB  = 9;
    localparam int RD_LSB  = 12;
    localparam int REG_W   = 3;
    localparam int HL_BIT  = 15;
    localparam int IMM_LSB = 16;
    localparam int IMM_W   = 16;

    // index into the register bank or the flag bank
    typedef logic [REG_W-1:0] reg_idx_t;

    // any encoding not listed here executes as a no-op
    typedef enum logic [OPC_W-1:0] {
        OP_LDI   = 6'h01,
        OP_ADD   = 6'h02,
        OP_SUB   = 6'h03,
        OP_AND   = 6'h04,
        OP_OR    = 6'h05,
        OP_XOR   = 6'h06,
        OP_SHL   = 6'h07,
        OP_SHR   = 6'h08,
        OP_CMPEQ = 6'h09,
        OP_CMPLT = 6'h0a,
        OP_LOAD  = 6'h0b,
        OP_STORE = 6'h0c,
        OP_BRF   = 6'h0d,
        OP_JMP   = 6'h0e,
        OP_HALT  = 6'h0f
    } opcode_t;

endpackage

`default_nettype wire
